// ==== pet_display_pkg.sv ====
package pet_display_pkg;

    // ==================================================================
    // Display geometry
    // ==================================================================
    localparam int FRAME_BYTES = 1024;   // 128 x 64 monochrome
    localparam int BYTE_IDX_W  = 10;

    // ==================================================================
    // States and animation frames
    // ==================================================================
    localparam int STATE_W = 4;
    localparam logic [STATE_W-1:0] ST_IDLE  = 4'd0;
    localparam logic [STATE_W-1:0] ST_SLEEP = 4'd1;
    localparam logic [STATE_W-1:0] ST_EAT   = 4'd2;
    localparam logic [STATE_W-1:0] ST_TEACH = 4'd4;
    localparam logic [STATE_W-1:0] ST_DEAD  = 4'd8;

    localparam int N_STATES    = 5;
    localparam int STATE_IDX_W = 3;
    localparam int MAX_FRAMES  = 8;
    localparam int FRAME_IDX_W = 3;

    // Dense index order: idle, sleep, eat, teach, dead
    localparam logic [N_STATES-1:0][3:0] FRAME_COUNT = {4'd8, 4'd7, 4'd5, 4'd4, 4'd6};

    localparam int SPRITE_ADDR_W = 16;   // {state idx, frame, byte idx}
    localparam int SPRITE_BYTES  = N_STATES * MAX_FRAMES * FRAME_BYTES;

    // ==================================================================
    // Stats and status bars
    // ==================================================================
    localparam int STAT_W  = 8;          // 0 to 100
    localparam int N_STATS = 3;          // happiness, hunger, sleep
    localparam logic [N_STATS-1:0][BYTE_IDX_W-1:0] BAR_BASE = {10'd224, 10'd144, 10'd64};
    localparam int BAR_ROWS       = 5;
    localparam int BAR_ROW_STRIDE = 8;
    localparam int BAR_SEGMENTS   = 5;
    localparam logic [7:0] SEG_FULL = 8'hEE;
    localparam logic [7:0] SEG_HALF = 8'hE0;

    // ==================================================================
    // APB and register map
    // ==================================================================
    localparam int PADDR_W      = 17;
    localparam int PDATA_W      = 32;
    localparam int REG_OFFSET_W = 5;
    localparam logic [REG_OFFSET_W-1:0] REG_CTRL   = 5'h00;  // Bit 0 animate
    localparam logic [REG_OFFSET_W-1:0] REG_STATE  = 5'h04;
    localparam logic [REG_OFFSET_W-1:0] REG_HAPPY  = 5'h08;
    localparam logic [REG_OFFSET_W-1:0] REG_HUNGER = 5'h0C;
    localparam logic [REG_OFFSET_W-1:0] REG_SLEEP  = 5'h10;
    localparam logic [REG_OFFSET_W-1:0] REG_FRAME  = 5'h14;  // Read only

    typedef union packed {
        struct packed {
            logic                                  spr_sel;
            logic [PADDR_W-REG_OFFSET_W-2:0]       unused;
            logic [REG_OFFSET_W-1:0]               offset;
        } reg_view;
        struct packed {
            logic                                  spr_sel;
            logic [SPRITE_ADDR_W-1:0]              addr;
        } spr_view;
    } apb_addr_u;

endpackage

// ==== pet_display_regs.sv ====
`timescale 1ns/1ps

module pet_display_regs (
    input  logic                                       clk,
    input  logic                                       i_rst,
    input  logic                                       i_psel,
    input  logic                                       i_penable,
    input  logic                                       i_pwrite,
    input  logic [pet_display_pkg::PADDR_W-1:0]        i_paddr,
    input  logic [pet_display_pkg::PDATA_W-1:0]        i_pwdata,
    input  logic [pet_display_pkg::FRAME_IDX_W-1:0]    i_frame_idx,
    output logic                                       o_pready,
    output logic [pet_display_pkg::PDATA_W-1:0]        o_prdata,
    output logic                                       o_pslverr,
    output logic [pet_display_pkg::STATE_W-1:0]        o_state_code,
    output logic                                       o_animate,
    output logic [pet_display_pkg::STAT_W-1:0]         o_happy,
    output logic [pet_display_pkg::STAT_W-1:0]         o_hunger,
    output logic [pet_display_pkg::STAT_W-1:0]         o_sleep,
    output logic                                       o_spr_we,
    output logic [pet_display_pkg::SPRITE_ADDR_W-1:0]  o_spr_addr,
    output logic [7:0]                                 o_spr_data
);

    pet_display_pkg::apb_addr_u addr;
    logic access;
    logic reg_hit;   // Offset maps to a register
    logic err;
    logic reg_wr;

    assign addr     = i_paddr;
    assign access   = i_psel & i_penable;
    assign o_pready = 1'b1;                 // Zero wait states

    // ==================================================================
    // Address decode and readback
    // ==================================================================
    always_comb begin
        reg_hit  = 1'b1;
        o_prdata = '0;
        case (addr.reg_view.offset)
            pet_display_pkg::REG_CTRL:   o_prdata[0] = o_animate;
            pet_display_pkg::REG_STATE:  o_prdata[pet_display_pkg::STATE_W-1:0] = o_state_code;
            pet_display_pkg::REG_HAPPY:  o_prdata[pet_display_pkg::STAT_W-1:0] = o_happy;
            pet_display_pkg::REG_HUNGER: o_prdata[pet_display_pkg::STAT_W-1:0] = o_hunger;
            pet_display_pkg::REG_SLEEP:  o_prdata[pet_display_pkg::STAT_W-1:0] = o_sleep;
            pet_display_pkg::REG_FRAME:  o_prdata[pet_display_pkg::FRAME_IDX_W-1:0] = i_frame_idx;
            default:                     reg_hit = 1'b0;
        endcase
        if (addr.reg_view.unused != '0) begin
            reg_hit = 1'b0;
        end
    end

    // Sprite space is write only, frame register is read only
    always_comb begin
        if (addr.spr_view.spr_sel) begin
            err = ~i_pwrite;
        end else begin
            err = ~reg_hit |
                  (i_pwrite & (addr.reg_view.offset == pet_display_pkg::REG_FRAME));
        end
    end

    assign o_pslverr = access & err;
    assign reg_wr    = access & i_pwrite & ~err & ~addr.reg_view.spr_sel;

    // Sprite RAM write port
    assign o_spr_we   = access & i_pwrite & addr.spr_view.spr_sel;
    assign o_spr_addr = addr.spr_view.addr;
    assign o_spr_data = i_pwdata[7:0];

    // ==================================================================
    // Register file
    // ==================================================================
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_animate    <= 1'b0;
            o_state_code <= pet_display_pkg::ST_IDLE;
            o_happy      <= '0;
            o_hunger     <= '0;
            o_sleep      <= '0;
        end else if (reg_wr) begin
            case (addr.reg_view.offset)
                pet_display_pkg::REG_CTRL:   o_animate    <= i_pwdata[0];
                pet_display_pkg::REG_STATE:  o_state_code <= i_pwdata[pet_display_pkg::STATE_W-1:0];
                pet_display_pkg::REG_HAPPY:  o_happy      <= i_pwdata[pet_display_pkg::STAT_W-1:0];
                pet_display_pkg::REG_HUNGER: o_hunger     <= i_pwdata[pet_display_pkg::STAT_W-1:0];
                pet_display_pkg::REG_SLEEP:  o_sleep      <= i_pwdata[pet_display_pkg::STAT_W-1:0];
                default: ;
            endcase
        end
    end

    // Access phase comes right after a setup phase on the same address
    a_apb_setup_access : assert property (@(posedge clk) disable iff (i_rst)
        access |-> $past(i_psel & ~i_penable) && $stable(i_paddr));

endmodule

// ==== bar_locator.sv ====
`timescale 1ns/1ps

module bar_locator (
    input  logic                                    clk,
    input  logic                                    i_rst,
    input  logic                                    i_byte_valid,
    input  logic [pet_display_pkg::BYTE_IDX_W-1:0]  i_byte_idx,
    output logic                                    o_valid,
    output logic [pet_display_pkg::BYTE_IDX_W-1:0]  o_byte_idx,
    output logic                                    o_bar_hit,
    output logic [1:0]                              o_stat_sel,
    output logic [2:0]                              o_segment
);

    localparam int BAR_SPAN = pet_display_pkg::BAR_ROWS * pet_display_pkg::BAR_ROW_STRIDE;

    logic       hit;
    logic [1:0] stat_sel;
    logic [2:0] segment;

    // Offset from each bar base, column within the row is offs % 8
    always_comb begin
        logic [pet_display_pkg::BYTE_IDX_W-1:0] offs;
        hit      = 1'b0;
        stat_sel = '0;
        segment  = '0;
        for (int k = 0; k < pet_display_pkg::N_STATS; k++) begin
            offs = i_byte_idx - pet_display_pkg::BAR_BASE[k];   // Wraps when below base
            if (offs < BAR_SPAN && offs[2:0] >= 3'd1 &&
                offs[2:0] <= pet_display_pkg::BAR_SEGMENTS) begin
                hit      = 1'b1;
                stat_sel = 2'(k);
                segment  = offs[2:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid   <= 1'b0;
            o_bar_hit <= 1'b0;
        end else begin
            o_valid   <= i_byte_valid;
            o_bar_hit <= i_byte_valid & hit;
        end
    end

    always_ff @(posedge clk) begin
        o_byte_idx <= i_byte_idx;
        o_stat_sel <= stat_sel;
        o_segment  <= segment;
    end

    a_segment_range : assert property (@(posedge clk) disable iff (i_rst)
        o_valid && o_bar_hit |-> o_segment inside {[1:pet_display_pkg::BAR_SEGMENTS]});

endmodule

// ==== frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer #(
    parameter int FRAME_TICKS = 2 ** 23
) (
    input  logic                                     clk,
    input  logic                                     i_rst,
    input  logic                                     i_animate,
    input  logic [pet_display_pkg::STATE_W-1:0]      i_state_code,
    output logic [pet_display_pkg::STATE_IDX_W-1:0]  o_state_idx,
    output logic                                     o_state_valid,
    output logic [pet_display_pkg::FRAME_IDX_W-1:0]  o_frame_idx
);

    localparam int TICK_W = (FRAME_TICKS > 1) ? $clog2(FRAME_TICKS) : 1;

    logic [TICK_W-1:0] tick_cnt;
    logic              step;
    logic [pet_display_pkg::FRAME_IDX_W-1:0] frame_cnt [pet_display_pkg::N_STATES];

    // One-hot-ish state code to dense index
    always_comb begin
        o_state_valid = 1'b1;
        case (i_state_code)
            pet_display_pkg::ST_IDLE:  o_state_idx = 3'd0;
            pet_display_pkg::ST_SLEEP: o_state_idx = 3'd1;
            pet_display_pkg::ST_EAT:   o_state_idx = 3'd2;
            pet_display_pkg::ST_TEACH: o_state_idx = 3'd3;
            pet_display_pkg::ST_DEAD:  o_state_idx = 3'd4;
            default: begin
                o_state_idx   = 3'd0;
                o_state_valid = 1'b0;
            end
        endcase
    end

    assign step = i_animate && (tick_cnt == TICK_W'(FRAME_TICKS - 1));

    // Tick counter only runs while animation is enabled
    always_ff @(posedge clk) begin
        if (i_rst) begin
            tick_cnt <= '0;
        end else if (i_animate) begin
            tick_cnt <= step ? '0 : tick_cnt + 1'b1;
        end
    end

    // All states step together, each wrapping at its own count
    always_ff @(posedge clk) begin
        for (int i = 0; i < pet_display_pkg::N_STATES; i++) begin
            if (i_rst) begin
                frame_cnt[i] <= '0;
            end else if (step) begin
                if (frame_cnt[i] == 3'(pet_display_pkg::FRAME_COUNT[i] - 1'b1))
                    frame_cnt[i] <= '0;
                else
                    frame_cnt[i] <= frame_cnt[i] + 1'b1;
            end
        end
    end

    assign o_frame_idx = o_state_valid ? frame_cnt[o_state_idx] : '0;

    for (genvar g = 0; g < pet_display_pkg::N_STATES; g++) begin : g_frame_chk
        a_frame_bound : assert property (@(posedge clk) disable iff (i_rst)
            frame_cnt[g] < pet_display_pkg::FRAME_COUNT[g]);
    end

endmodule

// ==== sprite_ram.sv ====
`timescale 1ns/1ps

module sprite_ram (
    input  logic                                       clk,
    input  logic                                       i_we,
    input  logic [pet_display_pkg::SPRITE_ADDR_W-1:0]  i_waddr,
    input  logic [7:0]                                 i_wdata,
    input  logic [pet_display_pkg::STATE_IDX_W-1:0]    i_state_idx,
    input  logic [pet_display_pkg::FRAME_IDX_W-1:0]    i_frame_idx,
    input  logic [pet_display_pkg::BYTE_IDX_W-1:0]     i_byte_idx,
    output logic [7:0]                                 o_rdata
);

    logic [7:0] mem [pet_display_pkg::SPRITE_BYTES];
    logic [pet_display_pkg::SPRITE_ADDR_W-1:0] raddr;

    // state * 8192 + frame * 1024 + byte
    assign raddr = {i_state_idx, i_frame_idx, i_byte_idx};

    // Writes past the last dead frame are dropped
    always_ff @(posedge clk) begin
        if (i_we && i_waddr < pet_display_pkg::SPRITE_BYTES) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        o_rdata <= mem[raddr];
    end

endmodule

// ==== pixel_compositor.sv ====
`timescale 1ns/1ps

module pixel_compositor (
    input  logic                                clk,
    input  logic                                i_rst,
    input  logic                                i_valid,
    input  logic                                i_bar_hit,
    input  logic [1:0]                          i_stat_sel,
    input  logic [2:0]                          i_segment,
    input  logic [pet_display_pkg::STAT_W-1:0]  i_happy,
    input  logic [pet_display_pkg::STAT_W-1:0]  i_hunger,
    input  logic [pet_display_pkg::STAT_W-1:0]  i_sleep,
    input  logic                                i_state_valid,
    input  logic [7:0]                          i_sprite_byte,
    output logic                                o_byte_valid,
    output logic [7:0]                          o_pixel_byte
);

    logic [pet_display_pkg::STAT_W-1:0] stat;
    int         thr_full;
    int         thr_half;
    logic [7:0] seg_byte;
    logic [7:0] bar_byte_q;
    logic       bar_hit_q;
    logic       state_valid_q;

    // ==================================================================
    // Bar segment rendering
    // ==================================================================
    always_comb begin
        case (i_stat_sel)
            2'd0:    stat = i_happy;
            2'd1:    stat = i_hunger;
            default: stat = i_sleep;
        endcase
        thr_full = 110 - 20 * int'(i_segment);   // 90, 70, 50, 30, 10
        thr_half = thr_full - 10;
        if (int'(stat) > thr_full)
            seg_byte = pet_display_pkg::SEG_FULL;
        else if (int'(stat) > thr_half)
            seg_byte = pet_display_pkg::SEG_HALF;
        else
            seg_byte = 8'h00;
    end

    // Same cycle as the sprite RAM read
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_byte_valid <= 1'b0;
            bar_hit_q    <= 1'b0;
        end else begin
            o_byte_valid <= i_valid;
            bar_hit_q    <= i_bar_hit;
        end
    end

    always_ff @(posedge clk) begin
        bar_byte_q    <= seg_byte;
        state_valid_q <= i_state_valid;
    end

    // Bars over sprite, blank for unknown state
    assign o_pixel_byte = bar_hit_q     ? bar_byte_q    :
                          state_valid_q ? i_sprite_byte : 8'h00;

endmodule

// ==== pet_display_top.sv ====
`timescale 1ns/1ps

module pet_display_top #(
    parameter int FRAME_TICKS = 2 ** 23
) (
    input  logic                                    clk,
    input  logic                                    i_rst,
    input  logic                                    i_psel,
    input  logic                                    i_penable,
    input  logic                                    i_pwrite,
    input  logic [pet_display_pkg::PADDR_W-1:0]     i_paddr,
    input  logic [pet_display_pkg::PDATA_W-1:0]     i_pwdata,
    output logic                                    o_pready,
    output logic [pet_display_pkg::PDATA_W-1:0]     o_prdata,
    output logic                                    o_pslverr,
    input  logic                                    i_byte_valid,
    input  logic [pet_display_pkg::BYTE_IDX_W-1:0]  i_byte_idx,
    output logic                                    o_byte_valid,
    output logic [7:0]                              o_pixel_byte
);

    logic [pet_display_pkg::STATE_W-1:0]       state_code;
    logic                                      animate;
    logic [pet_display_pkg::STAT_W-1:0]        happy;
    logic [pet_display_pkg::STAT_W-1:0]        hunger;
    logic [pet_display_pkg::STAT_W-1:0]        sleep;
    logic                                      spr_we;
    logic [pet_display_pkg::SPRITE_ADDR_W-1:0] spr_addr;
    logic [7:0]                                spr_data;
    logic [pet_display_pkg::STATE_IDX_W-1:0]   state_idx;
    logic                                      state_valid;
    logic [pet_display_pkg::FRAME_IDX_W-1:0]   frame_idx;
    logic                                      s1_valid;
    logic [pet_display_pkg::BYTE_IDX_W-1:0]    s1_byte_idx;
    logic                                      s1_bar_hit;
    logic [1:0]                                s1_stat_sel;
    logic [2:0]                                s1_segment;
    logic [7:0]                                sprite_byte;

    // ==================================================================
    // Decode
    // ==================================================================
    pet_display_regs u_regs (
        .clk(clk), .i_rst(i_rst),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata), .i_frame_idx(frame_idx),
        .o_pready(o_pready), .o_prdata(o_prdata), .o_pslverr(o_pslverr),
        .o_state_code(state_code), .o_animate(animate),
        .o_happy(happy), .o_hunger(hunger), .o_sleep(sleep),
        .o_spr_we(spr_we), .o_spr_addr(spr_addr), .o_spr_data(spr_data)
    );

    bar_locator u_locator (
        .clk(clk), .i_rst(i_rst),
        .i_byte_valid(i_byte_valid), .i_byte_idx(i_byte_idx),
        .o_valid(s1_valid), .o_byte_idx(s1_byte_idx), .o_bar_hit(s1_bar_hit),
        .o_stat_sel(s1_stat_sel), .o_segment(s1_segment)
    );

    // ==================================================================
    // Execute
    // ==================================================================
    frame_sequencer #(.FRAME_TICKS(FRAME_TICKS)) u_sequencer (
        .clk(clk), .i_rst(i_rst),
        .i_animate(animate), .i_state_code(state_code),
        .o_state_idx(state_idx), .o_state_valid(state_valid), .o_frame_idx(frame_idx)
    );

    sprite_ram u_sprite_ram (
        .clk(clk),
        .i_we(spr_we), .i_waddr(spr_addr), .i_wdata(spr_data),
        .i_state_idx(state_idx), .i_frame_idx(frame_idx), .i_byte_idx(s1_byte_idx),
        .o_rdata(sprite_byte)
    );

    // Result
    pixel_compositor u_compositor (
        .clk(clk), .i_rst(i_rst),
        .i_valid(s1_valid), .i_bar_hit(s1_bar_hit),
        .i_stat_sel(s1_stat_sel), .i_segment(s1_segment),
        .i_happy(happy), .i_hunger(hunger), .i_sleep(sleep),
        .i_state_valid(state_valid), .i_sprite_byte(sprite_byte),
        .o_byte_valid(o_byte_valid), .o_pixel_byte(o_pixel_byte)
    );

endmodule

// ==== tb_pet_display.sv ====
`timescale 1ns/1ps

module tb_pet_display;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int FRAME_TICKS  = 64;
    localparam int MAX_ROWS     = 1024;
    localparam int N_PROBE      = 17;
    localparam int N_SPRITE_WR  = 30 * N_PROBE;   // Every frame of every state
    localparam int ANIM_CYCLES  = 600;
    // CTRL readback and the disable transfer add four counted cycles
    localparam int ANIM_STEPS   = (ANIM_CYCLES + 4) / FRAME_TICKS;
    localparam int WATCHDOG_CYCLES =
        2 * (RESET_CYCLES + 3 * (N_SPRITE_WR + 64) + 2 * MAX_ROWS + 32 * 16 + ANIM_CYCLES);

    localparam logic [16:0] A_CTRL   = 17'h00;
    localparam logic [16:0] A_STATE  = 17'h04;
    localparam logic [16:0] A_HAPPY  = 17'h08;
    localparam logic [16:0] A_HUNGER = 17'h0C;
    localparam logic [16:0] A_SLEEP  = 17'h10;
    localparam logic [16:0] A_FRAME  = 17'h14;
    localparam logic [16:0] A_SPRITE = 17'h10000;  // Sprite select bit

    logic        clk;
    logic        i_rst;
    logic        i_psel;
    logic        i_penable;
    logic        i_pwrite;
    logic [16:0] i_paddr;
    logic [31:0] i_pwdata;
    logic        o_pready;
    logic [31:0] o_prdata;
    logic        o_pslverr;
    logic        i_byte_valid;
    logic [9:0]  i_byte_idx;
    logic        o_byte_valid;
    logic [7:0]  o_pixel_byte;

    // Dense order idle, sleep, eat, teach, dead
    int         frame_count [5] = '{6, 4, 5, 7, 8};
    logic [3:0] state_codes [5] = '{4'd0, 4'd1, 4'd2, 4'd4, 4'd8};
    int         stat_vals   [5] = '{0, 5, 34, 85, 100};
    // Indices outside every bar
    int         probe_idx [N_PROBE] = '{0, 1, 64, 70, 71, 72, 102, 105, 144, 150, 183,
                                        224, 230, 262, 265, 600, 1023};

    logic [7:0] model [40960];    // Sprite bytes written so far

    // Stimulus table
    int         tbl_idx    [MAX_ROWS];
    logic [3:0] tbl_state  [MAX_ROWS];
    logic [7:0] tbl_happy  [MAX_ROWS];
    logic [7:0] tbl_hunger [MAX_ROWS];
    logic [7:0] tbl_sleep  [MAX_ROWS];
    logic [7:0] tbl_exp    [MAX_ROWS];
    int         n_rows;

    logic [7:0] drv_exp;
    logic       v1;
    logic       v2;
    logic [7:0] e1;
    logic [7:0] e2;
    logic       checking;
    integer     seed;

    pet_display_top #(.FRAME_TICKS(FRAME_TICKS)) i_dut (
        .clk(clk), .i_rst(i_rst),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_pready(o_pready), .o_prdata(o_prdata), .o_pslverr(o_pslverr),
        .i_byte_valid(i_byte_valid), .i_byte_idx(i_byte_idx),
        .o_byte_valid(o_byte_valid), .o_pixel_byte(o_pixel_byte)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================================
    // Reference model
    // ==================================================================
    function automatic int state_index(input logic [3:0] code);
        for (int i = 0; i < 5; i++) begin
            if (state_codes[i] == code) return i;
        end
        return -1;
    endfunction

    // Two thresholds per segment
    function automatic logic [7:0] bar_segment(input int stat, input int seg);
        if (stat > 110 - 20 * seg) return 8'hEE;
        if (stat > 100 - 20 * seg) return 8'hE0;
        return 8'h00;
    endfunction

    function automatic logic [7:0] expected_byte(input int idx, input logic [3:0] code,
                                                 input int h, input int u, input int s,
                                                 input int steps);
        int stats [3];
        int off;
        int si;
        stats[0] = h;
        stats[1] = u;
        stats[2] = s;
        for (int k = 0; k < 3; k++) begin
            off = idx - (8 + 10 * k) * 8;     // Bar base
            if (off >= 0 && off < 40 && off % 8 >= 1 && off % 8 <= 5) begin
                return bar_segment(stats[k], off % 8);
            end
        end
        si = state_index(code);
        if (si < 0) return 8'h00;
        return model[si * 8192 + (steps % frame_count[si]) * 1024 + idx];
    endfunction

    // ==================================================================
    // Bus and check helpers
    // ==================================================================
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic apb_write(input logic [16:0] addr, input logic [31:0] data, output logic err);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b1;
        i_paddr   = addr;
        i_pwdata  = data;
        step();
        i_penable = 1'b1;                 // Access phase
        @(negedge clk);
        check("o_pready", o_pready, 1);
        err = o_pslverr;
        step();
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [16:0] addr, output logic [31:0] data, output logic err);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = addr;
        step();
        i_penable = 1'b1;
        @(negedge clk);
        check("o_pready", o_pready, 1);
        data = o_prdata;
        err  = o_pslverr;
        step();
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic reg_write(input logic [16:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check("o_pslverr", err, 0);
    endtask

    task automatic reg_read_check(input logic [16:0] addr, input logic [31:0] exp,
                                  input string name);
        logic [31:0] rdata;
        logic        err;
        apb_read(addr, rdata, err);
        check("o_pslverr", err, 0);
        check(name, rdata, exp);
    endtask

    task automatic add_row(input int idx, input logic [3:0] code,
                           input int h, input int u, input int s, input int steps);
        tbl_idx[n_rows]    = idx;
        tbl_state[n_rows]  = code;
        tbl_happy[n_rows]  = h;
        tbl_hunger[n_rows] = u;
        tbl_sleep[n_rows]  = s;
        tbl_exp[n_rows]    = expected_byte(idx, code, h, u, s, steps);
        n_rows++;
    endtask

    // Rows stream back to back, registers change only on an empty pipeline
    task automatic run_table();
        logic new_group;
        for (int r = 0; r < n_rows; r++) begin
            new_group = (r == 0) || tbl_state[r] != tbl_state[r-1] ||
                        tbl_happy[r] != tbl_happy[r-1] || tbl_hunger[r] != tbl_hunger[r-1] ||
                        tbl_sleep[r] != tbl_sleep[r-1];
            if (new_group) begin
                i_byte_valid = 1'b0;
                repeat (3) step();
                reg_write(A_STATE, tbl_state[r]);
                reg_write(A_HAPPY, tbl_happy[r]);
                reg_write(A_HUNGER, tbl_hunger[r]);
                reg_write(A_SLEEP, tbl_sleep[r]);
            end else if (r % 7 == 3) begin
                i_byte_valid = 1'b0;      // Gap in the stream
                step();
            end
            i_byte_valid = 1'b1;
            i_byte_idx   = tbl_idx[r];
            drv_exp      = tbl_exp[r];
            step();
        end
        i_byte_valid = 1'b0;
        repeat (3) step();
    endtask

    // Expected output two edges behind the driven index
    always @(posedge clk) begin
        v1 <= i_byte_valid;
        e1 <= drv_exp;
        v2 <= v1;
        e2 <= e1;
    end

    always @(negedge clk) begin
        if (checking) begin
            check("o_byte_valid", o_byte_valid, v2);
            if (v2 === 1'b1) check("o_pixel_byte", o_pixel_byte, e2);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $fatal(1, "Watchdog expired");
    end

    // ==================================================================
    // Test sequence
    // ==================================================================
    initial begin
        logic        err;
        logic [31:0] rdata;
        int          addr;
        logic [7:0]  data;
        logic [3:0]  code;
        seed         = 96152;
        i_rst        = 1'b1;
        i_psel       = 1'b0;
        i_penable    = 1'b0;
        i_pwrite     = 1'b0;
        i_paddr      = '0;
        i_pwdata     = '0;
        i_byte_valid = 1'b0;
        i_byte_idx   = '0;
        drv_exp      = '0;
        v1           = 1'b0;
        v2           = 1'b0;
        checking     = 1'b0;
        n_rows       = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        i_rst    = 1'b0;
        checking = 1'b1;
        repeat (4) step();                // Output idle after reset

        // Register readback and bus errors
        reg_write(A_STATE, 32'h8);
        reg_write(A_HAPPY, 32'h11);
        reg_write(A_HUNGER, 32'h22);
        reg_write(A_SLEEP, 32'h33);
        reg_read_check(A_CTRL, 32'h0, "REG_CTRL");
        reg_read_check(A_STATE, 32'h8, "REG_STATE");
        reg_read_check(A_HAPPY, 32'h11, "REG_HAPPY");
        reg_read_check(A_HUNGER, 32'h22, "REG_HUNGER");
        reg_read_check(A_SLEEP, 32'h33, "REG_SLEEP");
        reg_read_check(A_FRAME, 32'h0, "REG_FRAME");
        apb_write(A_FRAME, 32'h1, err);
        check("o_pslverr", err, 1);
        apb_write(17'h18, 32'h1, err);    // Unmapped
        check("o_pslverr", err, 1);
        apb_read(17'h1C, rdata, err);
        check("o_pslverr", err, 1);
        apb_read(A_SPRITE | 17'h5, rdata, err);
        check("o_pslverr", err, 1);

        // Random sprite bytes at every probe of every frame
        for (int s = 0; s < 5; s++) begin
            for (int f = 0; f < frame_count[s]; f++) begin
                for (int p = 0; p < N_PROBE; p++) begin
                    addr        = s * 8192 + f * 1024 + probe_idx[p];
                    data        = $random(seed);
                    model[addr] = data;
                    reg_write(A_SPRITE | 17'(addr), {24'h0, data});
                end
            end
        end

        // Bars and frame 0 sprites, last group has no valid state
        for (int g = 0; g < 6; g++) begin
            code = (g < 5) ? state_codes[g] : 4'd3;
            for (int k = 0; k < 3; k++) begin
                for (int r = 0; r < 5; r++) begin
                    for (int c = 1; c <= 5; c++) begin
                        add_row((8 + 10 * k) * 8 + 8 * r + c, code, stat_vals[g % 5],
                                stat_vals[(g + 1) % 5], stat_vals[(g + 2) % 5], 0);
                    end
                end
            end
            for (int p = 0; p < N_PROBE; p++) begin
                add_row(probe_idx[p], code, stat_vals[g % 5], stat_vals[(g + 1) % 5],
                        stat_vals[(g + 2) % 5], 0);
            end
        end
        run_table();

        // Animation, all states step together
        reg_write(A_STATE, 32'h4);
        reg_write(A_CTRL, 32'h1);
        reg_read_check(A_CTRL, 32'h1, "REG_CTRL");
        repeat (ANIM_CYCLES) step();
        reg_write(A_CTRL, 32'h0);
        apb_read(A_FRAME, rdata, err);
        check("o_pslverr", err, 0);
        check("REG_FRAME below count", rdata < 7, 1);
        check("REG_FRAME", rdata, ANIM_STEPS % 7);
        n_rows = 0;
        for (int s = 0; s < 5; s++) begin
            for (int p = 0; p < N_PROBE; p++) begin
                add_row(probe_idx[p], state_codes[s], 50, 50, 50, ANIM_STEPS);
            end
        end
        run_table();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== pet_display_top.f ====
pet_display_pkg.sv
pet_display_regs.sv
bar_locator.sv
frame_sequencer.sv
sprite_ram.sv
pixel_compositor.sv
pet_display_top.sv
tb_pet_display.sv

// ==== Bender.yml ====
package:
  name: pet_display

sources:
  - pet_display_pkg.sv
  - pet_display_regs.sv
  - bar_locator.sv
  - frame_sequencer.sv
  - sprite_ram.sv
  - pixel_compositor.sv
  - pet_display_top.sv
  - target: simulation
    files:
      - tb_pet_display.sv
